//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ecc_secded_link
FILELIST  := ecc_secded_link.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(SIM_LOG)

check: run
	grep -q "STATUS: PASS" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- ecc_code_pkg.sv
package ecc_code_pkg;

  // widest lane the column table covers
  localparam int LANE_WIDTH_MAX = 16;
  // height of one parity-check column
  localparam int COLUMN_WIDTH = 6;

  // parity bits needed for a data width, hsiao rows up to 64
  function automatic int parity_width(input int data_width);
    if (data_width <= 4) begin
      return 4;
    end else if (data_width <= 11) begin
      return 5;
    end else if (data_width <= 26) begin
      return 6;
    end else if (data_width <= 57) begin
      return 7;
    end else begin
      return 8;
    end
  endfunction

  // data bits low, parity bits high
  function automatic int codeword_width(input int data_width);
    return data_width + parity_width(data_width);
  endfunction

  // odd weight 3 columns, all distinct, none equal to a unit column
  function automatic logic [COLUMN_WIDTH-1:0] hsiao_column(input int unsigned bit_index);
    case (bit_index)
      0:       return 6'b000111;
      1:       return 6'b001011;
      2:       return 6'b001101;
      3:       return 6'b001110;
      4:       return 6'b010011;
      5:       return 6'b010101;
      6:       return 6'b010110;
      7:       return 6'b011001;
      8:       return 6'b011010;
      9:       return 6'b011100;
      10:      return 6'b100011;
      11:      return 6'b100101;
      12:      return 6'b100110;
      13:      return 6'b101001;
      14:      return 6'b101010;
      15:      return 6'b101100;
      // outside the table, never matches a syndrome
      default: return '0;
    endcase
  endfunction

endpackage

//--- ecc_decoder.sv
`timescale 1ns/1ns

module ecc_decoder #(
  parameter int LaneWidth = 16,
  localparam int ParityWidth = ecc_code_pkg::parity_width(LaneWidth),
  localparam int CodewordWidth = ecc_code_pkg::codeword_width(LaneWidth)
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rcv_valid,
  input  logic [CodewordWidth-1:0]   rcv_codeword,
  output logic                       dec_valid,
  output logic [LaneWidth-1:0]       dec_data,
  output ecc_status_pkg::ecc_class_e dec_class,
  output logic [ParityWidth-1:0]     dec_syndrome
);
  import ecc_code_pkg::*;
  import ecc_status_pkg::*;

  logic [LaneWidth-1:0]   rcv_data;
  logic [ParityWidth-1:0] rcv_parity;
  logic [ParityWidth-1:0] calc_parity;
  logic [ParityWidth-1:0] syndrome;
  logic [LaneWidth-1:0]   flip;
  logic                   odd_weight;
  logic                   parity_match;
  ecc_class_e             cls;

  if (LaneWidth > LANE_WIDTH_MAX || ParityWidth != COLUMN_WIDTH) begin : gen_width_check
    $error("ecc_decoder: lane width %0d not covered by column table", LaneWidth);
  end

  // codeword layout matches the encoder
  assign rcv_data   = rcv_codeword[LaneWidth-1:0];
  assign rcv_parity = rcv_codeword[CodewordWidth-1:LaneWidth];

  // recompute parity and match the syndrome against each data column
  always_comb begin
    logic [COLUMN_WIDTH-1:0] col;
    calc_parity = '0;
    flip        = '0;
    for (int i = 0; i < LaneWidth; i++) begin
      col = hsiao_column(i);
      for (int j = 0; j < ParityWidth; j++) begin
        calc_parity[j] = calc_parity[j] ^ (rcv_data[i] & col[j]);
      end
    end
    for (int i = 0; i < LaneWidth; i++) begin
      col     = hsiao_column(i);
      flip[i] = ((calc_parity ^ rcv_parity) == col);
    end
  end

  assign syndrome     = calc_parity ^ rcv_parity;
  assign odd_weight   = ^syndrome;
  // a unit column points at a parity bit and leaves the data as received
  assign parity_match = $onehot(syndrome);

  // even weight or unknown odd column is uncorrectable
  always_comb begin
    if (syndrome == '0) begin
      cls = ECC_NONE;
    end else if (odd_weight && ((|flip) || parity_match)) begin
      cls = ECC_CE;
    end else begin
      cls = ECC_DUE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid    <= 1'b0;
      dec_class    <= ECC_NONE;
      dec_syndrome <= '0;
    end else begin
      dec_valid <= rcv_valid;
      if (rcv_valid) begin
        dec_class    <= cls;
        dec_syndrome <= syndrome;
      end
    end
  end

  // flip is all zero unless a data column matched
  always_ff @(posedge clk) begin
    if (rcv_valid) begin
      dec_data <= rcv_data ^ flip;
    end
  end

endmodule

//--- ecc_encoder.sv
`timescale 1ns/1ns

module ecc_encoder #(
  parameter int LaneWidth = 16,
  localparam int ParityWidth = ecc_code_pkg::parity_width(LaneWidth),
  localparam int CodewordWidth = ecc_code_pkg::codeword_width(LaneWidth)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic [LaneWidth-1:0]     in_data,
  output logic                     enc_valid,
  output logic [CodewordWidth-1:0] enc_codeword
);
  import ecc_code_pkg::*;

  logic [ParityWidth-1:0] parity;

  // column table only defined for 6 parity bits up to 16 data bits
  if (LaneWidth > LANE_WIDTH_MAX || ParityWidth != COLUMN_WIDTH) begin : gen_width_check
    $error("ecc_encoder: lane width %0d not covered by column table", LaneWidth);
  end

  // parity bit j is the xor of all data bits whose column has bit j set
  always_comb begin
    logic [COLUMN_WIDTH-1:0] col;
    parity = '0;
    for (int i = 0; i < LaneWidth; i++) begin
      col = hsiao_column(i);
      for (int j = 0; j < ParityWidth; j++) begin
        parity[j] = parity[j] ^ (in_data[i] & col[j]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enc_valid <= 1'b0;
    end else begin
      enc_valid <= in_valid;
    end
  end

  // codeword only loads on a strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      enc_codeword <= {parity, in_data};
    end
  end

endmodule

//--- ecc_lane.sv
`timescale 1ns/1ns

module ecc_lane #(
  parameter int LaneWidth = 16,
  localparam int ParityWidth = ecc_code_pkg::parity_width(LaneWidth),
  localparam int CodewordWidth = ecc_code_pkg::codeword_width(LaneWidth)
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  logic [LaneWidth-1:0]       in_data,
  input  logic [CodewordWidth-1:0]   in_flip_mask,
  output logic                       dec_valid,
  output logic [LaneWidth-1:0]       dec_data,
  output ecc_status_pkg::ecc_class_e dec_class,
  output logic [ParityWidth-1:0]     dec_syndrome
);

  logic                     enc_valid;
  logic [CodewordWidth-1:0] enc_codeword;
  logic [CodewordWidth-1:0] flip_mask_q;
  logic                     rcv_valid;
  logic [CodewordWidth-1:0] rcv_codeword;

  ecc_encoder #(
    .LaneWidth(LaneWidth)
  ) u_encoder (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .enc_valid   (enc_valid),
    .enc_codeword(enc_codeword)
  );

  // mask rides one stage, lines up with the encoder output
  always_ff @(posedge clk) begin
    if (in_valid) begin
      flip_mask_q <= in_flip_mask;
    end
  end

  // faulty channel model, a set bit inverts that codeword bit
  assign rcv_valid    = enc_valid;
  assign rcv_codeword = enc_codeword ^ flip_mask_q;

  ecc_decoder #(
    .LaneWidth(LaneWidth)
  ) u_decoder (
    .clk         (clk),
    .rst         (rst),
    .rcv_valid   (rcv_valid),
    .rcv_codeword(rcv_codeword),
    .dec_valid   (dec_valid),
    .dec_data    (dec_data),
    .dec_class   (dec_class),
    .dec_syndrome(dec_syndrome)
  );

endmodule

//--- ecc_link_properties.sv
`timescale 1ns/1ns

module ecc_link_properties #(
  parameter int SyndromeWidth = ecc_code_pkg::COLUMN_WIDTH
) (
  input logic                                   clk,
  input logic                                   rst,
  input logic                                   stage_in_valid,
  input logic                                   stage_out_valid,
  input logic                                   class_valid,
  input ecc_status_pkg::ecc_class_e             class_value,
  input logic [SyndromeWidth-1:0]               syndrome,
  input logic [ecc_status_pkg::COUNT_WIDTH-1:0] ce_count,
  input logic [ecc_status_pkg::COUNT_WIDTH-1:0] due_count
);
  import ecc_status_pkg::*;

  // even weight syndrome is never corrected
  assert property (@(posedge clk) disable iff (rst)
    class_valid && !(^syndrome) |-> class_value != ECC_CE)
    else $error("even weight syndrome classified as corrected");

  // clean codeword
  assert property (@(posedge clk) disable iff (rst)
    class_valid && syndrome == '0 |-> class_value == ECC_NONE)
    else $error("zero syndrome not classified as clean");

  // one register stage per block
  assert property (@(posedge clk) disable iff (rst) stage_in_valid |=> stage_out_valid)
    else $error("valid did not follow its input after one cycle");
  assert property (@(posedge clk) disable iff (rst) !stage_in_valid |=> !stage_out_valid)
    else $error("valid raised without an input one cycle earlier");

  // event counters only move up
  assert property (@(posedge clk) disable iff (rst) ce_count >= $past(ce_count))
    else $error("ce_count decreased");
  assert property (@(posedge clk) disable iff (rst) due_count >= $past(due_count))
    else $error("due_count decreased");

endmodule

// decoder view, counters unused
bind ecc_decoder ecc_link_properties u_decoder_props (
  .clk            (clk),
  .rst            (rst),
  .stage_in_valid (rcv_valid),
  .stage_out_valid(dec_valid),
  .class_valid    (dec_valid),
  .class_value    (dec_class),
  .syndrome       (dec_syndrome),
  .ce_count       ('0),
  .due_count      ('0)
);

// merge view, no syndrome at word level
bind ecc_status_merge ecc_link_properties u_merge_props (
  .clk            (clk),
  .rst            (rst),
  .stage_in_valid (lane0_valid),
  .stage_out_valid(out_valid),
  .class_valid    (1'b0),
  .class_value    (out_class),
  .syndrome       ('0),
  .ce_count       (ce_count),
  .due_count      (due_count)
);

//--- ecc_secded_link.f
ecc_code_pkg.sv
ecc_status_pkg.sv
ecc_encoder.sv
ecc_decoder.sv
ecc_lane.sv
ecc_status_merge.sv
ecc_secded_link.sv
ecc_link_properties.sv
tb_ecc_secded_link.sv

//--- ecc_secded_link.sv
`timescale 1ns/1ns

module ecc_secded_link #(
  parameter int LaneWidth = 16,
  localparam int CodewordWidth = ecc_code_pkg::codeword_width(LaneWidth)
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   in_valid,
  input  logic [2*LaneWidth-1:0]                 in_data,
  input  logic [2*CodewordWidth-1:0]             in_flip_mask,
  output logic                                   out_valid,
  output logic [2*LaneWidth-1:0]                 out_data,
  output ecc_status_pkg::ecc_class_e             out_class,
  output logic [ecc_status_pkg::COUNT_WIDTH-1:0] ce_count,
  output logic [ecc_status_pkg::COUNT_WIDTH-1:0] due_count
);

  logic                       lane0_valid;
  logic [LaneWidth-1:0]       lane0_data;
  ecc_status_pkg::ecc_class_e lane0_class;
  logic [LaneWidth-1:0]       lane1_data;
  ecc_status_pkg::ecc_class_e lane1_class;

  // low half of word and mask
  ecc_lane #(
    .LaneWidth(LaneWidth)
  ) u_lane0 (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_data     (in_data[LaneWidth-1:0]),
    .in_flip_mask(in_flip_mask[CodewordWidth-1:0]),
    .dec_valid   (lane0_valid),
    .dec_data    (lane0_data),
    .dec_class   (lane0_class),
    .dec_syndrome()
  );

  // high half, valid redundant with lane 0
  ecc_lane #(
    .LaneWidth(LaneWidth)
  ) u_lane1 (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_data     (in_data[2*LaneWidth-1:LaneWidth]),
    .in_flip_mask(in_flip_mask[2*CodewordWidth-1:CodewordWidth]),
    .dec_valid   (),
    .dec_data    (lane1_data),
    .dec_class   (lane1_class),
    .dec_syndrome()
  );

  ecc_status_merge #(
    .LaneWidth(LaneWidth)
  ) u_merge (
    .clk        (clk),
    .rst        (rst),
    .lane0_valid(lane0_valid),
    .lane0_data (lane0_data),
    .lane0_class(lane0_class),
    .lane1_data (lane1_data),
    .lane1_class(lane1_class),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_class  (out_class),
    .ce_count   (ce_count),
    .due_count  (due_count)
  );

endmodule

//--- ecc_status_merge.sv
`timescale 1ns/1ns

module ecc_status_merge #(
  parameter int LaneWidth = 16
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   lane0_valid,
  input  logic [LaneWidth-1:0]                   lane0_data,
  input  ecc_status_pkg::ecc_class_e             lane0_class,
  input  logic [LaneWidth-1:0]                   lane1_data,
  input  ecc_status_pkg::ecc_class_e             lane1_class,
  output logic                                   out_valid,
  output logic [2*LaneWidth-1:0]                 out_data,
  output ecc_status_pkg::ecc_class_e             out_class,
  output logic [ecc_status_pkg::COUNT_WIDTH-1:0] ce_count,
  output logic [ecc_status_pkg::COUNT_WIDTH-1:0] due_count
);
  import ecc_status_pkg::*;

  ecc_class_e word_class;
  logic [1:0] ce_inc;
  logic [1:0] due_inc;

  // add 0..2, stick at all ones
  function automatic logic [COUNT_WIDTH-1:0] sat_add(
    input logic [COUNT_WIDTH-1:0] count,
    input logic [1:0]             inc
  );
    logic [COUNT_WIDTH:0] sum;
    sum = {1'b0, count} + {{(COUNT_WIDTH-1){1'b0}}, inc};
    return sum[COUNT_WIDTH] ? {COUNT_WIDTH{1'b1}} : sum[COUNT_WIDTH-1:0];
  endfunction

  // worst of the two lanes
  always_comb begin
    if (lane0_class == ECC_DUE || lane1_class == ECC_DUE) begin
      word_class = ECC_DUE;
    end else if (lane0_class == ECC_CE || lane1_class == ECC_CE) begin
      word_class = ECC_CE;
    end else begin
      word_class = ECC_NONE;
    end
  end

  // lane events per word
  assign ce_inc  = {1'b0, lane0_class == ECC_CE} + {1'b0, lane1_class == ECC_CE};
  assign due_inc = {1'b0, lane0_class == ECC_DUE} + {1'b0, lane1_class == ECC_DUE};

  // lanes run in lockstep, lane0 valid qualifies both
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_class <= ECC_NONE;
      ce_count  <= '0;
      due_count <= '0;
    end else begin
      out_valid <= lane0_valid;
      if (lane0_valid) begin
        out_class <= word_class;
        ce_count  <= sat_add(ce_count, ce_inc);
        due_count <= sat_add(due_count, due_inc);
      end
    end
  end

  // lane 1 carries the upper half
  always_ff @(posedge clk) begin
    if (lane0_valid) begin
      out_data <= {lane1_data, lane0_data};
    end
  end

endmodule

//--- ecc_status_pkg.sv
package ecc_status_pkg;

  // per lane and per word error class
  // ordered so that a larger value is the worse outcome
  typedef enum logic [1:0] {
    // clean codeword
    ECC_NONE = 2'd0,
    // single error, corrected
    ECC_CE   = 2'd1,
    // detected, not correctable
    ECC_DUE  = 2'd2
  } ecc_class_e;

  // saturating event counters
  localparam int COUNT_WIDTH = 16;

endpackage

//--- ecc_trace.txt
# word flip_mask expect class gap chk (mask bits 21:0 lane 0, 43:22 lane 1, parity high)
# class 0 none, 1 ce, 2 due; gap -1 draws a random idle gap; chk 0 skips the data compare
12345678 00000000000 12345678 0 2 1
deadbeef 00000000000 deadbeef 0 1 1
00000000 00000000000 00000000 0 0 1
ffffffff 00000000001 ffffffff 1 1 1
a5a5a5a5 00000008000 a5a5a5a5 1 1 1
0f0f0f0f 00000010000 0f0f0f0f 1 0 1
f0f0f0f0 00000200000 f0f0f0f0 1 0 1
13572468 00000400000 13572468 1 1 1
8badf00d 02000000000 8badf00d 1 1 1
cafebabe 04000000000 cafebabe 1 0 1
0badc0de 80000000000 0badc0de 1 2 1
11223344 00000000003 00000000 2 1 0
55667788 10000400000 00000000 2 1 0
99aabbcc 000c0000020 00000000 2 1 0
ddeeff00 00002000008 ddeeff00 1 0 1
01234567 00000030000 00000000 2 0 0
89abcdef 00000000000 89abcdef 0 -1 1
fedcba98 00100000100 fedcba98 1 -1 1
76543210 00000000000 76543210 0 0 1

//--- tb_ecc_secded_link.sv
`timescale 1ns/1ns

module tb_ecc_secded_link;
  import ecc_code_pkg::*;
  import ecc_status_pkg::*;

  localparam int lane_width   = 16;
  localparam int word_width   = 2 * lane_width;
  localparam int cw_width     = codeword_width(lane_width);
  localparam int mask_width   = 2 * cw_width;
  localparam int clk_period   = 20;
  localparam int reset_cycles = 4;
  localparam int latency      = 3;
  localparam int drain_margin = 6;
  localparam int count_max    = (1 << COUNT_WIDTH) - 1;
  // strobe edge to the sampling negedge of its result
  localparam logic [63:0] arrival_delay = 64'(latency * clk_period + clk_period / 2);

  // one word in flight
  typedef struct packed {
    logic [63:0]           issue_time;
    logic [word_width-1:0] data;
    logic [1:0]            cls;
    logic                  check_data;
    logic [1:0]            ce_inc;
    logic [1:0]            due_inc;
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  logic [word_width-1:0]  in_data;
  logic [mask_width-1:0]  in_flip_mask;
  logic                   out_valid;
  logic [word_width-1:0]  out_data;
  ecc_class_e             out_class;
  logic [COUNT_WIDTH-1:0] ce_count;
  logic [COUNT_WIDTH-1:0] due_count;

  expect_t expect_q[$];
  // running lane event sums
  int      exp_ce;
  int      exp_due;

  ecc_secded_link #(
    .LaneWidth(lane_width)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_flip_mask(in_flip_mask),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_class   (out_class),
    .ce_count    (ce_count),
    .due_count   (due_count)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  task automatic raise_failure();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    raise_failure();
  endtask

  // counters stick at all ones
  function automatic int add_saturating(input int count, input int inc);
    return (count + inc > count_max) ? count_max : count + inc;
  endfunction

  task automatic check_counters(input string where);
    assert (int'(ce_count) == exp_ce && int'(due_count) == exp_due)
      else report_error($sformatf("%s ce_count %0d due_count %0d, expected %0d and %0d",
                                  where, ce_count, due_count, exp_ce, exp_due));
  endtask

  // outputs sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    expect_t item;
    if (!rst && out_valid) begin
      assert (expect_q.size() > 0)
        else report_error("out_valid with no word outstanding");
      item = expect_q.pop_front();
      assert ($time - item.issue_time == arrival_delay)
        else report_error($sformatf("word strobed at %0t ns arrived off the 3 cycle latency",
                                    item.issue_time));
      assert (out_class == item.cls)
        else report_error($sformatf("out_class %0d, expected %0d", out_class, item.cls));
      // data of an uncorrectable word is undefined
      assert (!item.check_data || out_data == item.data)
        else report_error($sformatf("out_data %08h, expected %08h", out_data, item.data));
      exp_ce  = add_saturating(exp_ce, int'(item.ce_inc));
      exp_due = add_saturating(exp_due, int'(item.due_inc));
      check_counters("after output");
    end
  end

  initial begin
    int                    fd;
    int                    code;
    int                    fields;
    int                    line_no;
    int                    cls;
    int                    gap;
    int                    chk;
    int                    lane0_flips;
    int                    lane1_flips;
    int                    wait_cycles;
    string                 line;
    logic [word_width-1:0] word;
    logic [word_width-1:0] expect_word;
    logic [mask_width-1:0] mask;
    ecc_class_e            rule_class;
    expect_t               item;

    void'($urandom(32'h28a3));
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_data      = '0;
    in_flip_mask = '0;
    exp_ce       = 0;
    exp_due      = 0;
    line_no      = 0;

    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (out_valid == 1'b0 && out_class == ECC_NONE)
      else report_error("outputs not idle after reset");
    check_counters("after reset");

    fd = $fopen("ecc_trace.txt", "r");
    assert (fd != 0) else begin
      $display("could not open ecc_trace.txt for reading");
      raise_failure();
    end

    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      line_no++;
      // blank and comment lines
      if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %d %d %d", word, mask, expect_word, cls, gap, chk);
      assert (fields == 6) else begin
        $display("trace line %0d does not have six fields", line_no);
        raise_failure();
      end

      // class follows from the flip count per lane
      lane0_flips = $countones(mask[cw_width-1:0]);
      lane1_flips = $countones(mask[mask_width-1:cw_width]);
      assert (lane0_flips <= 2 && lane1_flips <= 2) else begin
        $display("trace line %0d flips more than two bits in one lane", line_no);
        raise_failure();
      end
      rule_class = (lane0_flips == 2 || lane1_flips == 2) ? ECC_DUE :
                   (lane0_flips == 1 || lane1_flips == 1) ? ECC_CE : ECC_NONE;
      assert (cls == int'(rule_class)) else begin
        $display("trace line %0d gives class %0d but its mask implies %0d",
                 line_no, cls, rule_class);
        raise_failure();
      end

      item.data       = expect_word;
      item.cls        = 2'(cls);
      item.check_data = (chk != 0);
      item.ce_inc     = {1'b0, lane0_flips == 1} + {1'b0, lane1_flips == 1};
      item.due_inc    = {1'b0, lane0_flips == 2} + {1'b0, lane1_flips == 2};

      @(posedge clk);
      in_valid        <= 1'b1;
      in_data         <= word;
      in_flip_mask    <= mask;
      item.issue_time = $time;
      expect_q.push_back(item);

      // negative gap draws 0 to 3 idle cycles
      if (gap < 0) begin
        gap = int'($urandom % 4);
      end
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
    end
    $fclose(fd);
    @(posedge clk);
    in_valid <= 1'b0;

    // wait for the last words to come out
    wait_cycles = 0;
    while (expect_q.size() > 0 && wait_cycles < latency + drain_margin) begin
      @(posedge clk);
      wait_cycles++;
    end

    if (expect_q.size() == 0) begin
      @(negedge clk);
      check_counters("end of trace");
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("timed out with %0d words still expected, output never arrived",
               expect_q.size());
      raise_failure();
    end
  end

endmodule
